// ==== hw/mc_bridge_macros.svh ====
`ifndef MC_BRIDGE_MACROS_SVH
`define MC_BRIDGE_MACROS_SVH

// Bus widths
`define MC_BRIDGE_DEV_ADDR_W 20
`define MC_BRIDGE_DWORD_W 64
`define MC_BRIDGE_SCRATCH_W 32
`define MC_BRIDGE_SCRATCH_ELS 256

// Tile coordinate widths
`define MC_BRIDGE_X_CORD_W 8
`define MC_BRIDGE_Y_CORD_W 8
`define MC_BRIDGE_POD_X_W 4
`define MC_BRIDGE_POD_Y_W 4

// Device address map
`define MC_BRIDGE_REG_DRAM_OFFSET 20'h00000
`define MC_BRIDGE_REG_DRAM_POD 20'h00008
`define MC_BRIDGE_REG_MY_CORD 20'h00010
`define MC_BRIDGE_REG_HOST_CORD 20'h00018
// Scratchpad spans 4 bytes per word from here
`define MC_BRIDGE_SCRATCH_BASE 20'h01000

`endif

// ==== hw/mem_if_pkg.sv ====
`include "mc_bridge_macros.svh"

package mem_if_pkg;

  typedef logic [`MC_BRIDGE_DEV_ADDR_W-1:0] dev_addr_t;

  typedef logic [`MC_BRIDGE_DWORD_W-1:0] dword_t;

  // Only uncached single-word accesses are handled
  typedef enum logic [1:0]
  {
    e_mem_uc_rd = 2'b00,
    e_mem_uc_wr = 2'b01
  } mem_msg_e;

  // log2 of access size in bytes
  typedef logic [2:0] mem_size_t;

  // Requester tag, returned untouched
  typedef logic [7:0] lce_id_t;

  // Same layout in both directions
  typedef struct packed
  {
    mem_msg_e msg_type;
    mem_size_t size;
    lce_id_t lce_id;
    dev_addr_t addr;
  } mem_header_s;

endpackage

// ==== hw/mc_bridge_pkg.sv ====
`include "mc_bridge_macros.svh"

package mc_bridge_pkg;

  typedef logic [`MC_BRIDGE_X_CORD_W-1:0] x_cord_t;
  typedef logic [`MC_BRIDGE_Y_CORD_W-1:0] y_cord_t;
  typedef logic [`MC_BRIDGE_POD_X_W-1:0] pod_x_t;
  typedef logic [`MC_BRIDGE_POD_Y_W-1:0] pod_y_t;

  // y sits above x in both coordinate forms
  typedef struct packed
  {
    y_cord_t y;
    x_cord_t x;
  } cord_t;

  typedef struct packed
  {
    pod_y_t y;
    pod_x_t x;
  } pod_cord_t;

  typedef logic [31:0] dram_offset_t;
  typedef logic [`MC_BRIDGE_SCRATCH_W-1:0] scratch_word_t;

  // Strobe bit positions
  localparam int unsigned num_targets = 5;
  localparam int unsigned sel_dram_offset_idx = 0;
  localparam int unsigned sel_dram_pod_idx = 1;
  localparam int unsigned sel_my_cord_idx = 2;
  localparam int unsigned sel_host_cord_idx = 3;
  localparam int unsigned sel_scratch_idx = 4;

  typedef logic [num_targets-1:0] reg_sel_t;

endpackage

// ==== hw/scratchpad_mem.sv ====
module scratchpad_mem
  #(parameter int unsigned els_p = 256
    , localparam int unsigned addr_w_lp = $clog2(els_p)
    )
  (input clk_i
   , input reset_i

   , input v_i
   , input w_i
   , input [addr_w_lp-1:0] addr_i
   , input mc_bridge_pkg::scratch_word_t data_i
   , output mc_bridge_pkg::scratch_word_t data_o
   );

  mc_bridge_pkg::scratch_word_t mem [els_p];

  always_ff @(posedge clk_i)
    begin
      if (v_i && w_i)
        mem[addr_i] <= data_i;
    end

  // Read register keeps its value until the next read
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        data_o <= '0;
      else if (v_i && !w_i)
        data_o <= mem[addr_i];
    end

endmodule

// ==== hw/mem_reg_decoder.sv ====
`include "mc_bridge_macros.svh"

module mem_reg_decoder
  #(parameter int unsigned scratchpad_els_p = `MC_BRIDGE_SCRATCH_ELS)
  (input clk_i
   , input reset_i

   , input mem_if_pkg::mem_header_s mem_fwd_header_i
   , input mem_if_pkg::dword_t mem_fwd_data_i
   , input mem_fwd_v_i
   , output logic mem_fwd_ready_and_o

   , output mem_if_pkg::mem_header_s mem_rev_header_o
   , output mem_if_pkg::dword_t mem_rev_data_o
   , output logic mem_rev_v_o
   , input mem_rev_ready_and_i

   , output mc_bridge_pkg::reg_sel_t r_v_o
   , output mc_bridge_pkg::reg_sel_t w_v_o
   , output mem_if_pkg::dev_addr_t addr_o
   , output mem_if_pkg::dword_t data_o
   , input mem_if_pkg::dword_t [mc_bridge_pkg::num_targets-1:0] rd_data_i
   );

  // First byte past the scratchpad window
  localparam mem_if_pkg::dev_addr_t scratch_end_lp =
    mem_if_pkg::dev_addr_t'(`MC_BRIDGE_SCRATCH_BASE + 4 * scratchpad_els_p);

  typedef enum logic [1:0] {S_IDLE, S_ACCESS, S_CAPTURE, S_RESP} state_e;

  state_e state_r, state_n;
  mem_if_pkg::mem_header_s header_r;
  mem_if_pkg::dword_t data_r;
  mem_if_pkg::dword_t rev_data_r;
  mem_if_pkg::dword_t rd_mux;
  mc_bridge_pkg::reg_sel_t sel_r, sel_n;
  logic fwd_accept;
  logic is_rd, is_wr;

  assign fwd_accept = mem_fwd_v_i & mem_fwd_ready_and_o;
  assign is_rd = (header_r.msg_type == mem_if_pkg::e_mem_uc_rd);
  assign is_wr = (header_r.msg_type == mem_if_pkg::e_mem_uc_wr);

  // Address match against the map, all zero when nothing hits
  always_comb
    begin
      sel_n = '0;
      sel_n[mc_bridge_pkg::sel_dram_offset_idx] =
        (mem_fwd_header_i.addr == `MC_BRIDGE_REG_DRAM_OFFSET);
      sel_n[mc_bridge_pkg::sel_dram_pod_idx] =
        (mem_fwd_header_i.addr == `MC_BRIDGE_REG_DRAM_POD);
      sel_n[mc_bridge_pkg::sel_my_cord_idx] =
        (mem_fwd_header_i.addr == `MC_BRIDGE_REG_MY_CORD);
      sel_n[mc_bridge_pkg::sel_host_cord_idx] =
        (mem_fwd_header_i.addr == `MC_BRIDGE_REG_HOST_CORD);
      sel_n[mc_bridge_pkg::sel_scratch_idx] =
        (mem_fwd_header_i.addr >= `MC_BRIDGE_SCRATCH_BASE)
        && (mem_fwd_header_i.addr < scratch_end_lp);
    end

  always_comb
    begin
      state_n = state_r;
      case (state_r)
        S_IDLE: if (mem_fwd_v_i) state_n = S_ACCESS;
        S_ACCESS: state_n = S_CAPTURE;
        S_CAPTURE: state_n = S_RESP;
        S_RESP: if (mem_rev_ready_and_i) state_n = S_IDLE;
        default: state_n = S_IDLE;
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          state_r <= S_IDLE;
          sel_r <= '0;
        end
      else
        begin
          state_r <= state_n;
          if (fwd_accept)
            sel_r <= sel_n;
        end
    end

  // One-hot select, so an OR of the gated inputs is enough
  always_comb
    begin
      rd_mux = '0;
      for (int i = 0; i < mc_bridge_pkg::num_targets; i++)
        if (sel_r[i])
          rd_mux = rd_mux | rd_data_i[i];
    end

  always_ff @(posedge clk_i)
    begin
      if (fwd_accept)
        begin
          header_r <= mem_fwd_header_i;
          data_r <= mem_fwd_data_i;
        end
      // Writes answer with zero data
      if (state_r == S_CAPTURE)
        rev_data_r <= is_rd ? rd_mux : '0;
    end

  assign r_v_o = ((state_r == S_ACCESS) && is_rd) ? sel_r : '0;
  assign w_v_o = ((state_r == S_ACCESS) && is_wr) ? sel_r : '0;
  assign addr_o = header_r.addr;
  assign data_o = data_r;

  assign mem_fwd_ready_and_o = (state_r == S_IDLE);
  assign mem_rev_v_o = (state_r == S_RESP);
  assign mem_rev_header_o = header_r;
  assign mem_rev_data_o = rev_data_r;

endmodule

// ==== hw/mc_bridge.sv ====
`include "mc_bridge_macros.svh"

module mc_bridge
  #(parameter int unsigned scratchpad_els_p = `MC_BRIDGE_SCRATCH_ELS)
  (input clk_i
   , input reset_i

   , input mem_if_pkg::mem_header_s mem_fwd_header_i
   , input mem_if_pkg::dword_t mem_fwd_data_i
   , input mem_fwd_v_i
   , output logic mem_fwd_ready_and_o

   , output mem_if_pkg::mem_header_s mem_rev_header_o
   , output mem_if_pkg::dword_t mem_rev_data_o
   , output logic mem_rev_v_o
   , input mem_rev_ready_and_i

   , output mc_bridge_pkg::dram_offset_t dram_offset_o
   , output mc_bridge_pkg::pod_cord_t dram_pod_o
   , output mc_bridge_pkg::cord_t my_cord_o
   , output mc_bridge_pkg::cord_t host_cord_o
   );

  localparam int unsigned scratch_addr_w_lp = $clog2(scratchpad_els_p);
  localparam int unsigned offset_w_lp = $bits(mc_bridge_pkg::dram_offset_t);
  localparam int unsigned pod_w_lp = $bits(mc_bridge_pkg::pod_cord_t);
  localparam int unsigned cord_w_lp = $bits(mc_bridge_pkg::cord_t);
  localparam int unsigned word_w_lp = `MC_BRIDGE_SCRATCH_W;

  mc_bridge_pkg::reg_sel_t r_v_lo, w_v_lo;
  mem_if_pkg::dev_addr_t addr_lo;
  mem_if_pkg::dword_t data_lo;
  mem_if_pkg::dword_t [mc_bridge_pkg::num_targets-1:0] rd_data_li;

  mem_reg_decoder
    #(.scratchpad_els_p(scratchpad_els_p))
    u_decoder
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.mem_fwd_header_i(mem_fwd_header_i)
       ,.mem_fwd_data_i(mem_fwd_data_i)
       ,.mem_fwd_v_i(mem_fwd_v_i)
       ,.mem_fwd_ready_and_o(mem_fwd_ready_and_o)
       ,.mem_rev_header_o(mem_rev_header_o)
       ,.mem_rev_data_o(mem_rev_data_o)
       ,.mem_rev_v_o(mem_rev_v_o)
       ,.mem_rev_ready_and_i(mem_rev_ready_and_i)
       ,.r_v_o(r_v_lo)
       ,.w_v_o(w_v_lo)
       ,.addr_o(addr_lo)
       ,.data_o(data_lo)
       ,.rd_data_i(rd_data_li)
       );

  mc_bridge_pkg::dram_offset_t dram_offset_r;
  mc_bridge_pkg::pod_cord_t dram_pod_r;
  mc_bridge_pkg::cord_t my_cord_r;
  mc_bridge_pkg::cord_t host_cord_r;

  // Each register keeps only the low bits that fit
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          dram_offset_r <= '0;
          dram_pod_r <= '0;
          my_cord_r <= '0;
          host_cord_r <= '0;
        end
      else
        begin
          if (w_v_lo[mc_bridge_pkg::sel_dram_offset_idx])
            dram_offset_r <= data_lo[offset_w_lp-1:0];
          if (w_v_lo[mc_bridge_pkg::sel_dram_pod_idx])
            dram_pod_r <= data_lo[pod_w_lp-1:0];
          if (w_v_lo[mc_bridge_pkg::sel_my_cord_idx])
            my_cord_r <= data_lo[cord_w_lp-1:0];
          if (w_v_lo[mc_bridge_pkg::sel_host_cord_idx])
            host_cord_r <= data_lo[cord_w_lp-1:0];
        end
    end

  // Word index from the byte address
  logic [scratch_addr_w_lp-1:0] scratch_addr;
  logic scratch_v;
  mc_bridge_pkg::scratch_word_t scratch_data_lo;

  assign scratch_addr = scratch_addr_w_lp'(addr_lo >> 2);
  assign scratch_v = r_v_lo[mc_bridge_pkg::sel_scratch_idx]
                     | w_v_lo[mc_bridge_pkg::sel_scratch_idx];

  scratchpad_mem
    #(.els_p(scratchpad_els_p))
    u_scratchpad
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.v_i(scratch_v)
       ,.w_i(w_v_lo[mc_bridge_pkg::sel_scratch_idx])
       ,.addr_i(scratch_addr)
       ,.data_i(data_lo[word_w_lp-1:0])
       ,.data_o(scratch_data_lo)
       );

  assign rd_data_li[mc_bridge_pkg::sel_dram_offset_idx] =
    {{(`MC_BRIDGE_DWORD_W-offset_w_lp){1'b0}}, dram_offset_r};
  assign rd_data_li[mc_bridge_pkg::sel_dram_pod_idx] =
    {{(`MC_BRIDGE_DWORD_W-pod_w_lp){1'b0}}, dram_pod_r};
  assign rd_data_li[mc_bridge_pkg::sel_my_cord_idx] =
    {{(`MC_BRIDGE_DWORD_W-cord_w_lp){1'b0}}, my_cord_r};
  assign rd_data_li[mc_bridge_pkg::sel_host_cord_idx] =
    {{(`MC_BRIDGE_DWORD_W-cord_w_lp){1'b0}}, host_cord_r};
  assign rd_data_li[mc_bridge_pkg::sel_scratch_idx] =
    {{(`MC_BRIDGE_DWORD_W-word_w_lp){1'b0}}, scratch_data_lo};

  assign dram_offset_o = dram_offset_r;
  assign dram_pod_o = dram_pod_r;
  assign my_cord_o = my_cord_r;
  assign host_cord_o = host_cord_r;

endmodule

// ==== verification/tb_mc_bridge.sv ====
`include "mc_bridge_macros.svh"

module tb_mc_bridge;

  localparam int unsigned max_stall = 4;
  localparam int unsigned n_ops = 120;
  // Reset and register tests, scratchpad, unmapped plus register reads, random mix
  localparam int unsigned n_requests = 4 + 8 + n_ops + (n_ops / 4 + 4) + n_ops;
  localparam time watchdog_time = n_requests * (max_stall + 6) * 8;
  localparam int unsigned els = `MC_BRIDGE_SCRATCH_ELS;

  logic clk_i, reset_i;
  logic mem_fwd_v_i, mem_fwd_ready_and_o, mem_rev_v_o, mem_rev_ready_and_i;
  mem_if_pkg::mem_header_s mem_fwd_header_i, mem_rev_header_o;
  mem_if_pkg::dword_t mem_fwd_data_i, mem_rev_data_o;
  mc_bridge_pkg::dram_offset_t dram_offset_o, model_offset;
  mc_bridge_pkg::pod_cord_t dram_pod_o, model_pod;
  mc_bridge_pkg::cord_t my_cord_o, host_cord_o, model_my_cord, model_host_cord;
  // Reference scratchpad with a written flag per word
  mc_bridge_pkg::scratch_word_t model_scratch [els];
  bit scratch_written [els];
  logic [31:0] rng_state;
  string cur_test;
  int error_count, test_errors, tests_run, tests_failed;

  mc_bridge u_dut
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.mem_fwd_header_i(mem_fwd_header_i), .mem_fwd_data_i(mem_fwd_data_i)
     ,.mem_fwd_v_i(mem_fwd_v_i), .mem_fwd_ready_and_o(mem_fwd_ready_and_o)
     ,.mem_rev_header_o(mem_rev_header_o), .mem_rev_data_o(mem_rev_data_o)
     ,.mem_rev_v_o(mem_rev_v_o), .mem_rev_ready_and_i(mem_rev_ready_and_i)
     ,.dram_offset_o(dram_offset_o), .dram_pod_o(dram_pod_o)
     ,.my_cord_o(my_cord_o), .host_cord_o(host_cord_o)
     );

  always #4 clk_i = ~clk_i;

  // LCG with swapped halves so the low bits are not periodic
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {rng_state[15:0], rng_state[31:16]};
  endfunction

  task automatic count_error();
    error_count++;
    test_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR %s: %s", cur_test, msg);
    count_error();
  endtask

  task automatic check_header(input string what, input mem_if_pkg::mem_header_s exp,
                              input mem_if_pkg::mem_header_s act);
    if (exp !== act)
      begin
        $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
        count_error();
      end
  endtask

  task automatic check_dword(input string what, input mem_if_pkg::dword_t exp,
                             input mem_if_pkg::dword_t act);
    if (exp !== act)
      begin
        $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
        count_error();
      end
  endtask

  task automatic check_cord(input string what, input mc_bridge_pkg::cord_t exp,
                            input mc_bridge_pkg::cord_t act);
    if (exp !== act)
      begin
        $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
        count_error();
      end
  endtask

  task automatic check_pod(input string what, input mc_bridge_pkg::pod_cord_t exp,
                           input mc_bridge_pkg::pod_cord_t act);
    if (exp !== act)
      begin
        $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
        count_error();
      end
  endtask

  task automatic check_offset(input string what, input mc_bridge_pkg::dram_offset_t exp,
                              input mc_bridge_pkg::dram_offset_t act);
    if (exp !== act)
      begin
        $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
        count_error();
      end
  endtask

  function automatic mem_if_pkg::dev_addr_t reg_addr(input int unsigned idx);
    case (idx)
      0: return `MC_BRIDGE_REG_DRAM_OFFSET;
      1: return `MC_BRIDGE_REG_DRAM_POD;
      2: return `MC_BRIDGE_REG_MY_CORD;
      default: return `MC_BRIDGE_REG_HOST_CORD;
    endcase
  endfunction

  function automatic bit in_scratch(input mem_if_pkg::dev_addr_t addr);
    return (addr >= `MC_BRIDGE_SCRATCH_BASE) && (addr < `MC_BRIDGE_SCRATCH_BASE + 4 * els);
  endfunction

  function automatic bit is_mapped(input mem_if_pkg::dev_addr_t addr);
    return (addr == reg_addr(0)) || (addr == reg_addr(1)) || (addr == reg_addr(2))
      || (addr == reg_addr(3)) || in_scratch(addr);
  endfunction

  // Applies a request to the model and returns the expected response data
  function automatic mem_if_pkg::dword_t model_access(input bit wr,
      input mem_if_pkg::dev_addr_t addr, input mem_if_pkg::dword_t data);
    logic [7:0] idx;
    mem_if_pkg::dword_t rd;
    idx = 8'(addr >> 2);
    rd = '0;
    if (addr == reg_addr(0))
      begin
        if (wr)
          model_offset = data[31:0];
        else
          rd = {32'b0, model_offset};
      end
    else if (addr == reg_addr(1))
      begin
        if (wr)
          model_pod = data[7:0];
        else
          rd = {56'b0, model_pod};
      end
    else if (addr == reg_addr(2))
      begin
        if (wr)
          model_my_cord = data[15:0];
        else
          rd = {48'b0, model_my_cord};
      end
    else if (addr == reg_addr(3))
      begin
        if (wr)
          model_host_cord = data[15:0];
        else
          rd = {48'b0, model_host_cord};
      end
    else if (in_scratch(addr))
      begin
        if (wr)
          begin
            model_scratch[idx] = data[31:0];
            scratch_written[idx] = 1'b1;
          end
        else
          rd = {32'b0, model_scratch[idx]};
      end
    return wr ? '0 : rd;
  endfunction

  task automatic access(input bit wr, input mem_if_pkg::dev_addr_t addr,
                        input mem_if_pkg::dword_t data);
    mem_if_pkg::mem_header_s hdr, seen_hdr;
    mem_if_pkg::dword_t exp_data, seen_data;
    int unsigned stall, lat;
    hdr.msg_type = wr ? mem_if_pkg::e_mem_uc_wr : mem_if_pkg::e_mem_uc_rd;
    hdr.size = 3'(next_rand());
    hdr.lce_id = 8'(next_rand());
    hdr.addr = addr;
    exp_data = model_access(wr, addr, data);
    stall = next_rand() % (max_stall + 1);
    mem_fwd_header_i = hdr;
    mem_fwd_data_i = data;
    mem_fwd_v_i = 1'b1;
    mem_rev_ready_and_i = (stall == 0);
    @(negedge clk_i);
    if (!mem_fwd_ready_and_o)
      report_problem("mem_fwd_ready_and_o low while the bridge is idle");
    @(posedge clk_i);
    #1;
    mem_fwd_v_i = 1'b0;
    mem_fwd_header_i = '0;
    mem_fwd_data_i = '0;
    lat = 0;
    @(negedge clk_i);
    while (!mem_rev_v_o)
      begin
        if (mem_fwd_ready_and_o)
          report_problem("mem_fwd_ready_and_o high while a response is pending");
        lat++;
        if (lat > 20)
          begin
            $display("ERROR %s: no response, mem_rev_v_o stayed low for 20 cycles", cur_test);
            $display("Finished with errors");
            $finish;
          end
        else
          @(negedge clk_i);
      end
    if (lat != 2)
      begin
        $display("CHECK FAILED %s latency: expected 2 actual %0d", cur_test, lat);
        count_error();
      end
    seen_hdr = mem_rev_header_o;
    seen_data = mem_rev_data_o;
    check_header("rev header", hdr, seen_hdr);
    check_dword("rev data", exp_data, seen_data);
    // Response must hold still under back-pressure
    while (stall > 0)
      begin
        @(posedge clk_i);
        #1;
        stall--;
        if (stall == 0)
          mem_rev_ready_and_i = 1'b1;
        @(negedge clk_i);
        if (!mem_rev_v_o || mem_fwd_ready_and_o)
          report_problem("handshake signals changed while the response was stalled");
        check_header("held header", seen_hdr, mem_rev_header_o);
        check_dword("held data", seen_data, mem_rev_data_o);
      end
    @(posedge clk_i);
    #1;
    mem_rev_ready_and_i = 1'b0;
    if (!mem_fwd_ready_and_o || mem_rev_v_o)
      report_problem("bridge did not return to idle after the response handshake");
    check_offset("dram_offset_o", model_offset, dram_offset_o);
    check_pod("dram_pod_o", model_pod, dram_pod_o);
    check_cord("my_cord_o", model_my_cord, my_cord_o);
    check_cord("host_cord_o", model_host_cord, host_cord_o);
  endtask

  // Kind 0 is a register, 1 a scratchpad word and 2 an unmapped address
  task automatic random_access(input int unsigned kind);
    mem_if_pkg::dev_addr_t addr;
    int unsigned idx;
    bit wr;
    wr = next_rand() % 2;
    idx = next_rand() % els;
    if (kind == 0)
      addr = reg_addr(next_rand() % 4);
    else if (kind == 1)
      begin
        addr = `MC_BRIDGE_SCRATCH_BASE + 4 * idx;
        wr = wr | !scratch_written[idx];
      end
    else
      begin
        addr = (next_rand() % 2) ? 20'(next_rand() % 64) : 20'(next_rand());
        while (is_mapped(addr))
          addr = 20'(next_rand());
      end
    access(wr, addr, {next_rand(), next_rand()});
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0)
      $display("TEST %s: pass", cur_test);
    else
      begin
        tests_failed++;
        $display("TEST %s: FAIL, %0d errors", cur_test, test_errors);
      end
    test_errors = 0;
  endtask

  initial
    begin
      #(watchdog_time);
      $display("ERROR watchdog: the run did not complete within %0t", watchdog_time);
      $display("Finished with errors");
      $finish;
    end

  initial
    begin
      clk_i = 1'b0;
      reset_i = 1'b1;
      mem_fwd_v_i = 1'b0;
      mem_fwd_header_i = '0;
      mem_fwd_data_i = '0;
      mem_rev_ready_and_i = 1'b0;
      rng_state = 32'h6be2_7728;
      {model_offset, model_pod, model_my_cord, model_host_cord} = '0;
      {error_count, test_errors, tests_run, tests_failed} = '0;
      repeat (2) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      cur_test = "reset_state";
      if (!mem_fwd_ready_and_o || mem_rev_v_o)
        report_problem("handshake outputs wrong after reset");
      for (int i = 0; i < 4; i++)
        access(1'b0, reg_addr(i), '0);
      finish_test();

      cur_test = "register_access";
      for (int i = 0; i < 4; i++)
        begin
          access(1'b1, reg_addr(i), {next_rand(), next_rand()});
          access(1'b0, reg_addr(i), '0);
        end
      finish_test();

      cur_test = "scratchpad_access";
      repeat (n_ops) random_access(1);
      finish_test();

      cur_test = "unmapped_access";
      repeat (n_ops / 4) random_access(2);
      for (int i = 0; i < 4; i++)
        access(1'b0, reg_addr(i), '0);
      finish_test();

      cur_test = "random_mix";
      repeat (n_ops) random_access(next_rand() % 3);
      finish_test();

      $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
               error_count);
      if (error_count == 0)
        $display("Finished with no errors");
      else
        $display("Finished with errors");
      $finish;
    end

endmodule

// ==== mc_bridge.f ====
+incdir+hw
hw/mem_if_pkg.sv
hw/mc_bridge_pkg.sv
hw/scratchpad_mem.sv
hw/mem_reg_decoder.sv
hw/mc_bridge.sv
verification/tb_mc_bridge.sv

// ==== Bender.yml ====
package:
  name: mc_bridge

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_if_pkg.sv
      - hw/mc_bridge_pkg.sv
      - hw/scratchpad_mem.sv
      - hw/mem_reg_decoder.sv
      - hw/mc_bridge.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_mc_bridge.sv
